// File: files.f
src/gfx_pkg.sv
src/display_timings.sv
src/line_draw.sv
src/fb_clear.sv
src/fb_arbiter.sv
src/framebuffer.sv
src/draw_sequencer.sv
src/line_scene.sv
tests/line_scene_assertions.sv
tests/tb_line_scene.sv

// File: tests/tb_line_scene.sv
/* drives line commands into line_scene and compares scanned frames
   with a reference image, all endpoints stay inside 64x48 */
`timescale 1ns/10ps

module tb_line_scene;
    import gfx_pkg::*;

    localparam int frame_len  = 152 * 104;      // pixel clocks per frame
    localparam int wait_limit = 3 * 152 * 104;  // three frames at most
    localparam logic [11:0] colours [16] = '{
        12'h000, 12'h124, 12'h724, 12'h085, 12'ha53, 12'h655, 12'hccc, 12'hfef,
        12'hf05, 12'hfa0, 12'hfe2, 12'h0e3, 12'h2af, 12'h879, 12'hf7a, 12'hfff
    };

    logic        clk_pix = 1'b0;
    logic        rst_n;
    line_cmd_t   cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        dvi_hsync;
    logic        dvi_vsync;
    logic        dvi_de;
    rgb_t        dvi_rgb;
    logic [3:0]  ref_img [48][64];  // model index per fb pixel
    logic [31:0] lfsr;
    int          passed, failed, mark;
    int          bad_pixels, bad_timing, hs_pulses, de_count;
    int          vs_low_count;
    line_cmd_t   c;

    line_scene dut0 (
        .clk_pix, .rst_n, .cmd, .cmd_valid, .cmd_ready,
        .dvi_hsync, .dvi_vsync, .dvi_de, .dvi_rgb
    );

    always #20 clk_pix = ~clk_pix;  // 40 ns period

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;  // galois step
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // bresenham, every octant, both endpoints drawn
    function automatic void plot_model(input line_cmd_t l);
        int x, y, x1, y1, dx, dy, stx, sty, err, e2;
        x   = l.x0;
        y   = l.y0;
        x1  = l.x1;
        y1  = l.y1;
        dx  = (x1 > x) ? x1 - x : x - x1;
        dy  = (y1 > y) ? y - y1 : y1 - y;  // negative magnitude
        stx = (x1 > x) ? 1 : -1;
        sty = (y1 > y) ? 1 : -1;
        err = dx + dy;
        for (int n = 0; n < 128; n++) begin
            ref_img[y][x] = l.cidx;  // later lines overwrite
            if (x == x1 && y == y1) break;
            e2 = 2 * err;
            if (e2 >= dy) begin
                err += dy;
                x   += stx;
            end
            if (e2 <= dx) begin
                err += dx;
                y   += sty;
            end
        end
    endfunction

    task automatic give_up(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $finish;
    endtask

    task automatic await_ready();
        int t;
        t = 0;
        while (!cmd_ready && t < wait_limit) begin
            @(negedge clk_pix);
            t++;
        end
        if (!cmd_ready) give_up("timed out waiting for cmd_ready");
    endtask

    // stops on the first sample after the vsync pulse ends
    task automatic find_frame_start();
        int t;
        t = 0;
        while (dvi_vsync && t < wait_limit) begin
            @(negedge clk_pix);
            t++;
        end
        while (!dvi_vsync && t < wait_limit) begin
            @(negedge clk_pix);
            t++;
        end
        if (t >= wait_limit) give_up("timed out waiting for a vertical sync pulse");
    endtask

    task automatic check_count(input string what, input int got, input int want);
        if (got != want) begin
            $display("ERR %0t %s got %0d expected %0d", $time, what, got, want);
            bad_timing++;
        end
    endtask

    task automatic scan_frame();
        int   n, low, shown;
        logic prev_hs;
        rgb_t want;
        n            = 0;
        low          = 0;
        shown        = 0;
        prev_hs      = 1'b1;
        bad_pixels   = 0;
        bad_timing   = 0;
        hs_pulses    = 0;
        vs_low_count = 0;
        find_frame_start();
        repeat (frame_len) begin
            if (dvi_de) begin
                want = rgb_t'(colours[ref_img[n / 256][(n % 128) / 2]]);  // 2x scale
                if (dvi_rgb !== want) begin
                    bad_pixels++;
                    if (shown < 6) $display("ERR %0t dvi_rgb at (%0d,%0d) got %h expected %h",
                        $time, n % 128, n / 128, dvi_rgb, want);
                    shown++;
                end
                n++;
            end
            if (!dvi_vsync) vs_low_count++;
            if (!dvi_hsync) low++;
            if (prev_hs && !dvi_hsync) hs_pulses++;
            if (!prev_hs && dvi_hsync) begin
                check_count("dvi_hsync pulse width", low, 8);
                low = 0;
            end
            prev_hs = dvi_hsync;
            @(negedge clk_pix);
        end
        de_count = n;
    endtask

    // inputs change on the falling edge, taken at the next rising one
    task automatic send_line(input line_cmd_t l);
        cmd       = l;
        cmd_valid = 1'b1;
        await_ready();
        @(negedge clk_pix);
        plot_model(l);
    endtask

    task automatic report_test(input string name, input int bad);
        int total;
        total = bad + dut0.chk0.fails - mark;  // own checks plus assertions
        mark  = dut0.chk0.fails;
        if (total == 0) begin
            passed++;
            $display("test %s: pass", name);
        end else begin
            failed++;
            $display("test %s: fail, %0d errors", name, total);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        cmd       = '0;
        cmd_valid = 1'b0;
        lfsr      = 32'hfc99_8db0;
        passed    = 0;
        failed    = 0;
        mark      = 0;
        foreach (ref_img[r, k]) ref_img[r][k] = 4'h0;  // cleared screen
        repeat (4) @(negedge clk_pix);
        rst_n = 1'b1;
        repeat (2) @(negedge clk_pix);
        report_test("1 reset state", 0);

        await_ready();  // clear finished
        scan_frame();
        check_count("dvi_hsync pulses", hs_pulses, 104);
        check_count("dvi_vsync low cycles", vs_low_count, 2 * 152);  // two lines
        check_count("dvi_de cycles", de_count, 128 * 96);
        report_test("2 display timing", bad_timing);
        report_test("3 cleared frame", bad_pixels);

        send_line(line_cmd_t'{x0: 7'd4, y0: 7'd10, x1: 7'd40, y1: 7'd10, cidx: 4'h3});
        send_line(line_cmd_t'{x0: 7'd50, y0: 7'd44, x1: 7'd50, y1: 7'd3, cidx: 4'h8});
        send_line(line_cmd_t'{x0: 7'd30, y0: 7'd40, x1: 7'd8, y1: 7'd18, cidx: 4'hb});
        send_line(line_cmd_t'{x0: 7'd60, y0: 7'd45, x1: 7'd60, y1: 7'd45, cidx: 4'hf});
        cmd_valid = 1'b0;
        await_ready();
        scan_frame();
        report_test("4 fixed lines", bad_pixels + bad_timing);

        repeat (20) begin
            c.x0   = fb_coord_t'(take_bits(6));
            c.y0   = fb_coord_t'(take_bits(6) % 48);  // rows 0 to 47
            c.x1   = fb_coord_t'(take_bits(6));
            c.y1   = fb_coord_t'(take_bits(6) % 48);
            c.cidx = cidx_t'(take_bits(4));
            send_line(c);  // valid stays high between lines
        end
        cmd_valid = 1'b0;
        await_ready();
        scan_frame();
        report_test("5 random lines", bad_pixels + bad_timing);

        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tests/line_scene_assertions.sv
/* bound into line_scene, expects its internal wishbone nets by name
   display checks assume the reduced 128x96 timing */
`timescale 1ns/10ps

module line_scene_assertions (
    input logic             clk_pix,
    input logic             rst_n,
    input logic             cmd_valid,
    input logic             cmd_ready,
    input logic             line_done,
    input gfx_pkg::wb_req_t req_clear,
    input gfx_pkg::wb_req_t req_line,
    input gfx_pkg::wb_req_t req_fb,
    input logic             ack_clear,
    input logic             ack_line,
    input logic             ack_fb,
    input logic             dvi_hsync,
    input logic             dvi_vsync,
    input logic             dvi_de,
    input gfx_pkg::rgb_t    dvi_rgb
);
    int   fails = 0;  // running total of failed checks
    logic drawing;    // command taken, line not finished

    function automatic void count_failure(input string what);
        $error("%s", what);
        fails++;
    endfunction

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            drawing <= 1'b0;
        end else if (cmd_valid && cmd_ready) begin
            drawing <= 1'b1;  // accepted this cycle
        end else if (line_done) begin
            drawing <= 1'b0;
        end
    end

    // sampled on the falling edge, outputs settle after the rising one
    reset_idle: assert property (@(negedge clk_pix) (!rst_n || $rose(rst_n)) |->
        (dvi_hsync && dvi_vsync && !dvi_de && dvi_rgb == 12'h000 && !cmd_ready))
        else count_failure("outputs not idle around reset");

    hsync_width: assert property (@(posedge clk_pix) disable iff (!rst_n)
        $fell(dvi_hsync) |-> ##8 $rose(dvi_hsync))  // 8 clocks low
        else count_failure("dvi_hsync pulse is not 8 cycles wide");

    rgb_blank: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !dvi_de |-> dvi_rgb == 12'h000)
        else count_failure("dvi_rgb not black outside data enable");

    busy_not_ready: assert property (@(posedge clk_pix) disable iff (!rst_n)
        drawing |-> !cmd_ready)
        else count_failure("cmd_ready high while a line is drawn");

    clear_hold: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (req_clear.stb && !ack_clear) |=> (req_clear.stb && $stable(req_clear.adr)))
        else count_failure("clearer dropped or changed its request before ack");

    line_hold: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (req_line.stb && !ack_line) |=> (req_line.stb && $stable(req_line.adr)))
        else count_failure("line drawer dropped or changed its request before ack");

    ack_granted: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !(ack_fb && !req_fb.stb) && !(ack_clear && !req_clear.stb)
        && !(ack_line && !req_line.stb))
        else count_failure("ack seen without a granted strobe");

    acks_apart: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !(ack_clear && ack_line))
        else count_failure("both masters acked in the same cycle");

endmodule

bind line_scene line_scene_assertions chk0 (
    .clk_pix, .rst_n, .cmd_valid, .cmd_ready, .line_done,
    .req_clear, .req_line, .req_fb, .ack_clear, .ack_line, .ack_fb,
    .dvi_hsync, .dvi_vsync, .dvi_de, .dvi_rgb
);

// File: src/line_scene.sv
/* top level, pixel clock domain only
   line commands must use on-screen framebuffer coordinates */
`timescale 1ns/10ps

module line_scene (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  gfx_pkg::line_cmd_t cmd,
    input  logic               cmd_valid,
    output logic               cmd_ready,
    output logic               dvi_hsync,
    output logic               dvi_vsync,
    output logic               dvi_de,
    output gfx_pkg::rgb_t      dvi_rgb
);
    import gfx_pkg::*;

    scr_coord_t sx, sy;
    logic       hsync, vsync, de, frame;
    logic       clear_start, clear_done, line_start, line_done;
    line_cmd_t  line_cmd;
    wb_req_t    req_clear, req_line, req_fb;  // wishbone requests
    logic       ack_clear, ack_line, ack_fb;

    display_timings timing0 (
        .clk_pix, .rst_n, .sx, .sy, .hsync, .vsync, .de, .frame, .line()
    );

    draw_sequencer seq0 (
        .clk_pix, .rst_n, .frame, .cmd, .cmd_valid, .cmd_ready,
        .clear_start, .clear_done, .line_start, .line_cmd, .line_done
    );

    fb_clear clear0 (
        .clk_pix, .rst_n, .start(clear_start),
        .wb_out(req_clear), .wb_ack(ack_clear), .done(clear_done)
    );

    line_draw draw0 (
        .clk_pix, .rst_n, .start(line_start), .cmd(line_cmd),
        .wb_out(req_line), .wb_ack(ack_line), .done(line_done)
    );

    fb_arbiter arb0 (
        .clk_pix, .rst_n, .req_clear, .ack_clear, .req_line, .ack_line,
        .req_fb, .ack_fb
    );

    framebuffer fb0 (
        .clk_pix, .rst_n, .wb_in(req_fb), .wb_ack(ack_fb),
        .sx, .sy, .hsync, .vsync, .de,  // line pulse not needed here
        .dvi_hsync, .dvi_vsync, .dvi_de, .dvi_rgb
    );

endmodule

// File: src/draw_sequencer.sv
/* clears the framebuffer after the first frame start, then takes line
   commands one at a time, cmd_ready low while busy */
`timescale 1ns/10ps

module draw_sequencer (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  logic               frame,
    input  gfx_pkg::line_cmd_t cmd,
    input  logic               cmd_valid,
    output logic               cmd_ready,
    output logic               clear_start,
    input  logic               clear_done,
    output logic               line_start,
    output gfx_pkg::line_cmd_t line_cmd,
    input  logic               line_done
);
    import gfx_pkg::*;

    seq_state_t state;

    assign cmd_ready = (state == seq_ready);

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state       <= seq_idle;
            clear_start <= 1'b0;
            line_start  <= 1'b0;
        end else begin
            clear_start <= 1'b0;  // both starts are pulses
            line_start  <= 1'b0;
            case (state)
                seq_idle: if (frame) begin
                    clear_start <= 1'b1;
                    state       <= seq_clear;
                end
                seq_clear: if (clear_done) state <= seq_ready;
                seq_ready: if (cmd_valid) begin
                    line_start <= 1'b1;  // cmd taken this cycle
                    state      <= seq_draw;
                end
                default: if (line_done) state <= seq_ready;  // draw
            endcase
        end
    end

    // command payload, held for the drawer
    always_ff @(posedge clk_pix) begin
        if (cmd_ready && cmd_valid) line_cmd <= cmd;
    end

endmodule

// File: src/framebuffer.sv
/* 3072 x 4 index memory, wishbone write port with one-cycle ack
   display side reads at half screen resolution, one cycle latency */
`timescale 1ns/10ps

module framebuffer (
    input  logic                clk_pix,
    input  logic                rst_n,
    input  gfx_pkg::wb_req_t    wb_in,
    output logic                wb_ack,
    input  gfx_pkg::scr_coord_t sx,
    input  gfx_pkg::scr_coord_t sy,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                de,
    output logic                dvi_hsync,
    output logic                dvi_vsync,
    output logic                dvi_de,
    output gfx_pkg::rgb_t       dvi_rgb
);
    import gfx_pkg::*;

    cidx_t     mem [fb_width * fb_height];
    cidx_t     rd_cidx;
    fb_coord_t rd_x, rd_y;
    logic      wr_req;

    assign wr_req = wb_in.cyc && wb_in.stb && !wb_ack;  // first cycle of request

    always_comb begin
        rd_x = fb_coord_t'(sx[7:0] / fb_scale);  // screen to fb pixel
        rd_y = fb_coord_t'(sy[7:0] / fb_scale);
    end

    // write port and registered display read
    always_ff @(posedge clk_pix) begin
        if (wr_req && wb_in.we) begin
            mem[wb_in.adr] <= wb_in.dat;
        end
        if (de) begin
            rd_cidx <= mem[fb_addr(rd_x, rd_y)];  // only inside active area
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            dvi_hsync <= 1'b1;
            dvi_vsync <= 1'b1;
            dvi_de    <= 1'b0;
        end else begin
            wb_ack    <= wr_req;  // single cycle, master then moves on
            dvi_hsync <= hsync;   // match read latency
            dvi_vsync <= vsync;
            dvi_de    <= de;
        end
    end

    assign dvi_rgb = dvi_de ? palette(rd_cidx) : '0;  // black in blanking

endmodule

// File: src/fb_arbiter.sv
/* two wishbone masters onto one write port, clearer wins
   grant moves only while the current owner has cyc low */
`timescale 1ns/10ps

module fb_arbiter (
    input  logic             clk_pix,
    input  logic             rst_n,
    input  gfx_pkg::wb_req_t req_clear,
    output logic             ack_clear,
    input  gfx_pkg::wb_req_t req_line,
    output logic             ack_line,
    output gfx_pkg::wb_req_t req_fb,
    input  logic             ack_fb
);
    import gfx_pkg::*;

    logic gnt_line;  // 0 grants the clearer
    logic own_cyc;   // granted master is mid cycle

    assign own_cyc = gnt_line ? req_line.cyc : req_clear.cyc;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            gnt_line <= 1'b0;
        end else if (!own_cyc) begin
            if (req_clear.cyc) begin
                gnt_line <= 1'b0;  // priority to the clearer
            end else if (req_line.cyc) begin
                gnt_line <= 1'b1;
            end
        end
    end

    always_comb begin
        req_fb    = gnt_line ? req_line : req_clear;
        ack_clear = ack_fb && !gnt_line;  // ack only to the owner
        ack_line  = ack_fb && gnt_line;
    end

endmodule

// File: src/fb_clear.sv
/* writes index 0 to all 3072 framebuffer pixels, two cycles per pixel */
`timescale 1ns/10ps

module fb_clear (
    input  logic             clk_pix,
    input  logic             rst_n,
    input  logic             start,
    output gfx_pkg::wb_req_t wb_out,
    input  logic             wb_ack,
    output logic             done
);
    import gfx_pkg::*;

    logic    busy;
    fb_adr_t adr;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            adr  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                adr  <= '0;  // sweep from the top left
            end else if (busy && wb_ack) begin
                if (adr == fb_adr_t'(fb_width * fb_height - 1)) begin
                    busy <= 1'b0;  // last pixel written
                    done <= 1'b1;
                end else begin
                    adr <= adr + 1'b1;
                end
            end
        end
    end

    // cyc stays up across the sweep, adr advances on ack
    assign wb_out = '{cyc: busy, stb: busy, we: busy, adr: adr, dat: cidx_t'(0)};

endmodule

// File: src/line_draw.sv
/* bresenham walker, all octants, one pixel per acked wishbone cycle
   endpoints must lie inside the 64x48 framebuffer, no clipping */
`timescale 1ns/10ps

module line_draw (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  logic               start,
    input  gfx_pkg::line_cmd_t cmd,
    output gfx_pkg::wb_req_t   wb_out,
    input  logic               wb_ack,
    output logic               done
);
    import gfx_pkg::*;

    line_state_t state;
    fb_coord_t   x, y, x1, y1;  // current pixel and end point
    cidx_t       cidx;
    logic        right, down;  // step directions
    logic signed [8:0] dx, dy;  // dy is kept negative
    logic signed [8:0] err;
    logic signed [9:0] e2;
    fb_coord_t   abs_dx, abs_dy;
    logic        step_x, step_y, last;

    always_comb begin
        abs_dx = (x1 > x) ? x1 - x : x - x1;  // valid in init
        abs_dy = (y1 > y) ? y1 - y : y - y1;
        e2     = {err, 1'b0};
        step_x = (e2 >= dy);
        step_y = (e2 <= dx);
        last   = (x == x1) && (y == y1);
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            state <= ln_idle;
        end else begin
            case (state)
                ln_idle: if (start) state <= ln_init;
                ln_init: state <= ln_walk;
                ln_walk: if (wb_ack && last) state <= ln_done;
                default: state <= ln_idle;  // done lasts one cycle
            endcase
        end
    end

    // command latch and walk registers
    always_ff @(posedge clk_pix) begin
        case (state)
            ln_idle: begin
                x    <= cmd.x0;  // latch command
                y    <= cmd.y0;
                x1   <= cmd.x1;
                y1   <= cmd.y1;
                cidx <= cmd.cidx;
            end
            ln_init: begin
                right <= (x1 >= x);
                down  <= (y1 >= y);
                dx    <= {2'b00, abs_dx};
                dy    <= -$signed({2'b00, abs_dy});
                err   <= $signed({2'b00, abs_dx}) - $signed({2'b00, abs_dy});
            end
            ln_walk: if (wb_ack && !last) begin
                if (step_x) x <= right ? x + 1'b1 : x - 1'b1;
                if (step_y) y <= down ? y + 1'b1 : y - 1'b1;
                err <= err + (step_x ? dy : 9'sd0) + (step_y ? dx : 9'sd0);
            end
            default: ;
        endcase
    end

    always_comb begin
        wb_out.cyc = (state == ln_walk);  // held until ack
        wb_out.stb = (state == ln_walk);
        wb_out.we  = (state == ln_walk);
        wb_out.adr = fb_addr(x, y);
        wb_out.dat = cidx;
        done       = (state == ln_done);  // one pulse after last ack
    end

endmodule

// File: src/display_timings.sv
/* reduced 128x96 raster, counters start in blanking so the first
   cycle after reset is the frame start */
`timescale 1ns/10ps

module display_timings (
    input  logic               clk_pix,
    input  logic               rst_n,
    output gfx_pkg::scr_coord_t sx,
    output gfx_pkg::scr_coord_t sy,
    output logic               hsync,
    output logic               vsync,
    output logic               de,
    output logic               frame,
    output logic               line
);
    import gfx_pkg::*;

    scr_coord_t nx, ny;  // counter values for the next cycle
    logic       h_wrap;

    always_comb begin
        h_wrap = (sx == h_total - 1);
        nx = h_wrap ? '0 : scr_coord_t'(sx + 1);
        ny = sy;
        if (h_wrap) begin
            ny = (sy == v_total - 1) ? '0 : scr_coord_t'(sy + 1);  // next line
        end
    end

    // outputs registered together with the counters, all in step
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx    <= scr_coord_t'(h_total - 1);  // last blanking pixel
            sy    <= scr_coord_t'(v_total - 1);
            hsync <= 1'b1;  // syncs idle high
            vsync <= 1'b1;
            de    <= 1'b0;
            frame <= 1'b0;
            line  <= 1'b0;
        end else begin
            sx    <= nx;
            sy    <= ny;
            hsync <= !(nx >= h_active + h_front && nx < h_active + h_front + h_sync);
            vsync <= !(ny >= v_active + v_front && ny < v_active + v_front + v_sync);
            de    <= (nx < h_active) && (ny < v_active);
            frame <= (nx == 0) && (ny == 0);
            line  <= (nx == 0);
        end
    end

endmodule

// File: src/gfx_pkg.sv
/* shared geometry, types and palette for the line drawing subsystem
   geometry is fixed here, modules take no parameters */
package gfx_pkg;

    localparam int h_active = 128;  // visible pixels per line
    localparam int h_front  = 4;
    localparam int h_sync   = 8;
    localparam int h_back   = 12;
    localparam int h_total  = h_active + h_front + h_sync + h_back;  // 152

    localparam int v_active = 96;  // visible lines per frame
    localparam int v_front  = 2;
    localparam int v_sync   = 2;
    localparam int v_back   = 4;
    localparam int v_total  = v_active + v_front + v_sync + v_back;  // 104

    localparam int fb_width  = 64;
    localparam int fb_height = 48;
    localparam int fb_scale  = 2;  // screen pixels per fb pixel, both axes

    typedef logic signed [8:0] scr_coord_t;  // screen coordinate
    typedef logic [6:0]        fb_coord_t;   // framebuffer coordinate
    typedef logic [11:0]       fb_adr_t;     // row * 64 + column
    typedef logic [3:0]        cidx_t;       // colour index
    typedef logic [3:0]        chan_t;       // one colour channel

    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_t;

    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        fb_adr_t adr;
        cidx_t   dat;
    } wb_req_t;  // wishbone classic master request

    typedef struct packed {
        fb_coord_t x0;
        fb_coord_t y0;
        fb_coord_t x1;
        fb_coord_t y1;
        cidx_t     cidx;
    } line_cmd_t;

    typedef enum logic [1:0] {seq_idle, seq_clear, seq_ready, seq_draw} seq_state_t;
    typedef enum logic [1:0] {ln_idle, ln_init, ln_walk, ln_done} line_state_t;

    function automatic fb_adr_t fb_addr(fb_coord_t x, fb_coord_t y);
        return fb_adr_t'(y) * fb_adr_t'(fb_width) + fb_adr_t'(x);
    endfunction

    function automatic rgb_t palette(cidx_t cidx);
        case (cidx)
            4'h0:    return 12'h000;  // black
            4'h1:    return 12'h124;  // navy
            4'h2:    return 12'h724;  // plum
            4'h3:    return 12'h085;  // teal
            4'h4:    return 12'ha53;  // brown
            4'h5:    return 12'h655;  // slate
            4'h6:    return 12'hccc;  // light grey
            4'h7:    return 12'hfef;  // off white
            4'h8:    return 12'hf05;  // red
            4'h9:    return 12'hfa0;  // orange
            4'ha:    return 12'hfe2;  // yellow
            4'hb:    return 12'h0e3;  // green
            4'hc:    return 12'h2af;  // sky blue
            4'hd:    return 12'h879;  // lavender grey
            4'he:    return 12'hf7a;  // pink
            default: return 12'hfff;  // white
        endcase
    endfunction

endpackage
